//--- verilog/iic_config_macros.svh
// ==============================
// bus timing, device addresses and table size
// for the HDMI transmitter configuration master
// include in any file that needs one of these values
// ==============================

`ifndef IIC_CONFIG_MACROS_SVH
`define IIC_CONFIG_MACROS_SVH

// clocks per quarter bit, 200 MHz gives a 30 us bit
`define IIC_PHASE_CYCLES 1500

`define IIC_MUX_ADDR     7'h74  // bus multiplexer
`define IIC_MUX_CHANNEL  8'h20  // channel 5, transmitter side
`define ADV_DEV_ADDR     7'h39  // HDMI transmitter

`define ADV_CFG_ENTRIES  63     // register writes after channel select

`endif

//--- verilog/iic_pkg.sv
// ==============================
// I2C bus types shared by the write engine,
// the sequencer and the top level
// ==============================

`default_nettype none

package iic_pkg;

   typedef logic [6:0] dev_addr_t;  // 7-bit target address

   // mux frame is two bytes, register frame is three
   typedef enum logic {
      FRAME_MUX,
      FRAME_REG
   } frame_kind_e;

   typedef enum logic [2:0] {
      IDLE,
      START,
      BIT_LOW,   // scl low, sda updated mid-way
      BIT_HIGH,  // scl high, data valid
      STOP,
      GAP        // bus free time
   } iic_state_e;

endpackage

`default_nettype wire

//--- verilog/adv_cfg_pkg.sv
// ==============================
// types for the transmitter register table
// and the configuration sequencer
// ==============================

`default_nettype none

package adv_cfg_pkg;

   typedef logic [5:0] cfg_index_t;  // table position
   typedef logic [7:0] cfg_addr_t;   // register address
   typedef logic [7:0] cfg_data_t;   // register value

   // power-up order of the sequencer
   typedef enum logic [1:0] {
      MUX_RESET,  // multiplexer reset pulse
      MUX_WRITE,  // channel select frame
      REG_WRITE,  // one frame per table entry
      FINISHED
   } seq_state_e;

endpackage

`default_nettype wire

//--- verilog/adv_cfg_rom.sv
// ==============================
// transmitter configuration table, register address and value
// per index, read combinationally by the sequencer's index
// entries past the end return zero
// ==============================

`default_nettype none

module adv_cfg_rom (
   input  adv_cfg_pkg::cfg_index_t index,
   output adv_cfg_pkg::cfg_addr_t  reg_addr,
   output adv_cfg_pkg::cfg_data_t  reg_data
);

   logic [15:0] entry;  // {address, data}

   assign reg_addr = entry[15:8];
   assign reg_data = entry[7:0];

   always_comb begin
      case (index)
         6'd0:    entry = {8'h41, 8'h10};  // power up
         6'd1:    entry = {8'h0B, 8'hC7};  // spdif
         6'd2:    entry = {8'h14, 8'h02};  // 16-bit audio words
         6'd3:    entry = {8'h15, 8'h00};  // 24-bit rgb 4:4:4 in
         6'd4:    entry = {8'h16, 8'h32};  // 8-bit colour, rising edge
         6'd5:    entry = {8'h17, 8'h60};  // sync polarity low
         6'd6:    entry = {8'h3C, 8'h02};  // vic
         6'd7:    entry = {8'h0A, 8'h10};  // audio select
         6'd8:    entry = {8'h55, 8'h00};  // rgb out
         6'd9:    entry = {8'h73, 8'h01};  // two audio channels
         6'd10:   entry = {8'h9D, 8'h60};  // pixel clock undivided
         6'd11:   entry = {8'hAF, 8'h06};  // hdmi mode, no hdcp
         // sync generator timing
         6'd12:   entry = {8'hD7, 8'h04};
         6'd13:   entry = {8'hD8, 8'h03};
         6'd14:   entry = {8'hD9, 8'hE0};
         6'd15:   entry = {8'hDA, 8'h24};
         6'd16:   entry = {8'hDB, 8'h06};
         6'd17:   entry = {8'hF9, 8'h00};  // fixed i2c address
         // fixed registers
         6'd18:   entry = {8'h3B, 8'hE0};
         6'd19:   entry = {8'h44, 8'h00};
         6'd20:   entry = {8'h48, 8'h00};
         6'd21:   entry = {8'h94, 8'hC0};
         6'd22:   entry = {8'h96, 8'h00};
         6'd23:   entry = {8'h98, 8'h03};
         6'd24:   entry = {8'h99, 8'h02};
         6'd25:   entry = {8'h9A, 8'hE0};
         6'd26:   entry = {8'h9B, 8'h18};
         6'd27:   entry = {8'h9C, 8'h30};
         6'd28:   entry = {8'h9F, 8'h00};
         6'd29:   entry = {8'hA1, 8'h00};
         6'd30:   entry = {8'hA2, 8'hA4};
         6'd31:   entry = {8'hA3, 8'hA4};
         6'd32:   entry = {8'hA4, 8'h08};
         6'd33:   entry = {8'hA5, 8'h04};
         6'd34:   entry = {8'hA6, 8'h00};
         6'd35:   entry = {8'hA7, 8'h00};
         6'd36:   entry = {8'hA8, 8'h00};
         6'd37:   entry = {8'hA9, 8'h00};
         6'd38:   entry = {8'hAA, 8'h00};
         6'd39:   entry = {8'hAB, 8'h40};
         6'd40:   entry = {8'hB9, 8'h00};
         6'd41:   entry = {8'hBA, 8'h10};
         6'd42:   entry = {8'hBB, 8'h00};
         6'd43:   entry = {8'hC7, 8'h00};
         6'd44:   entry = {8'hCD, 8'h00};
         6'd45:   entry = {8'hCE, 8'h01};
         6'd46:   entry = {8'hCF, 8'h04};
         6'd47:   entry = {8'hD0, 8'h3C};
         6'd48:   entry = {8'hD1, 8'hFF};
         6'd49:   entry = {8'hD2, 8'h80};
         6'd50:   entry = {8'hD3, 8'h80};
         6'd51:   entry = {8'hD4, 8'h80};
         6'd52:   entry = {8'hD5, 8'h00};
         6'd53:   entry = {8'hD6, 8'h00};
         6'd54:   entry = {8'hDC, 8'h00};
         6'd55:   entry = {8'hDD, 8'h00};
         6'd56:   entry = {8'hDE, 8'h10};
         6'd57:   entry = {8'hDF, 8'h01};
         6'd58:   entry = {8'hE0, 8'h3C};
         6'd59:   entry = {8'hE2, 8'h00};
         6'd60:   entry = {8'hE3, 8'h00};
         6'd61:   entry = {8'hE4, 8'h60};
         6'd62:   entry = {8'hFA, 8'h00};
         default: entry = 16'h0000;
      endcase
   end

endmodule

`default_nettype wire

//--- verilog/iic_write_engine.sv
// ==============================
// write-only I2C master for one frame at a time
// start pulse loads the frame, busy stays high
// through stop and the bus-free gap
// ==============================

`default_nettype none

`include "iic_config_macros.svh"

module iic_write_engine #(
   parameter int phase_cycles = `IIC_PHASE_CYCLES
) (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    start,
   input  iic_pkg::frame_kind_e    kind,
   input  adv_cfg_pkg::cfg_addr_t  reg_addr,
   input  adv_cfg_pkg::cfg_data_t  reg_data,
   output logic                    busy,
   output logic                    scl,
   output logic                    sda
);

   localparam int phase_w = (phase_cycles > 1) ? $clog2(phase_cycles) : 1;
   localparam int frame_bits = 27;
   localparam logic [4:0] mux_last = 5'd17;  // 2 bytes + 2 acks
   localparam logic [4:0] reg_last = 5'd26;  // 3 bytes + 3 acks

   iic_pkg::iic_state_e     state;
   logic [phase_w-1:0]      phase_cnt;
   logic                    phase_end;
   logic [1:0]              step;       // phase within the state
   logic [4:0]              bit_cnt;
   logic [4:0]              frame_last;
   logic [frame_bits-1:0]   shift_q;
   logic [frame_bits-1:0]   frame_load;
   iic_pkg::dev_addr_t      dev_addr;
   adv_cfg_pkg::cfg_addr_t  second_byte;

   assign busy = (state != iic_pkg::IDLE);
   assign phase_end = (phase_cnt == phase_w'(phase_cycles - 1));

   // device address and mux data follow from the frame kind
   assign dev_addr = (kind == iic_pkg::FRAME_MUX) ? `IIC_MUX_ADDR : `ADV_DEV_ADDR;
   assign second_byte = (kind == iic_pkg::FRAME_MUX) ? `IIC_MUX_CHANNEL : reg_addr;

   // addr + write, byte, byte, each followed by a released ack
   // mux frames stop after the second ack
   assign frame_load = {dev_addr, 1'b0, 1'b1, second_byte, 1'b1, reg_data, 1'b1};

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         phase_cnt <= '0;
      end else if (state == iic_pkg::IDLE || phase_end) begin
         phase_cnt <= '0;
      end else begin
         phase_cnt <= phase_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (state == iic_pkg::IDLE && start) begin
         shift_q <= frame_load;
         frame_last <= (kind == iic_pkg::FRAME_MUX) ? mux_last : reg_last;
      end else if (state == iic_pkg::BIT_LOW && phase_end && step == 2'd0) begin
         shift_q <= {shift_q[frame_bits-2:0], 1'b1};  // msb went to sda
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= iic_pkg::IDLE;
         step <= 2'd0;
         bit_cnt <= 5'd0;
         scl <= 1'b1;
         sda <= 1'b1;
      end else begin
         case (state)
            iic_pkg::IDLE: begin
               step <= 2'd0;
               bit_cnt <= 5'd0;
               if (start) begin
                  state <= iic_pkg::START;
               end
            end
            iic_pkg::START: begin
               if (phase_end) begin
                  if (step == 2'd0) begin
                     sda <= 1'b0;  // start condition, scl still high
                     step <= 2'd1;
                  end else begin
                     scl <= 1'b0;
                     step <= 2'd0;
                     state <= iic_pkg::BIT_LOW;
                  end
               end
            end
            iic_pkg::BIT_LOW: begin
               if (phase_end) begin
                  if (step == 2'd0) begin
                     sda <= shift_q[frame_bits-1];  // mid low half
                     step <= 2'd1;
                  end else begin
                     scl <= 1'b1;
                     step <= 2'd0;
                     state <= iic_pkg::BIT_HIGH;
                  end
               end
            end
            iic_pkg::BIT_HIGH: begin
               if (phase_end) begin
                  if (step == 2'd0) begin
                     step <= 2'd1;
                  end else begin
                     scl <= 1'b0;
                     step <= 2'd0;
                     if (bit_cnt == frame_last) begin
                        state <= iic_pkg::STOP;
                     end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                        state <= iic_pkg::BIT_LOW;
                     end
                  end
               end
            end
            iic_pkg::STOP: begin
               if (phase_end) begin
                  step <= step + 1'b1;
                  case (step)
                     2'd0:    sda <= 1'b0;
                     2'd1:    scl <= 1'b1;
                     2'd2:    sda <= 1'b1;  // stop condition
                     default: state <= iic_pkg::GAP;
                  endcase
               end
            end
            default: begin
               // bus free, both lines high for four phases
               if (phase_end) begin
                  step <= step + 1'b1;
                  if (step == 2'd3) begin
                     state <= iic_pkg::IDLE;
                  end
               end
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- verilog/cfg_sequencer.sv
// ==============================
// power-up order: mux reset, channel select,
// then one register frame per table entry
// done holds once the last frame has left the bus
// ==============================

`default_nettype none

`include "iic_config_macros.svh"

module cfg_sequencer (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    busy,
   output logic                    start,
   output iic_pkg::frame_kind_e    kind,
   output adv_cfg_pkg::cfg_index_t index,
   output logic                    iic_mux_rst,
   output logic                    done
);

   localparam adv_cfg_pkg::cfg_index_t last_index =
      adv_cfg_pkg::cfg_index_t'(`ADV_CFG_ENTRIES - 1);

   adv_cfg_pkg::seq_state_e state;
   logic                    busy_q;
   logic                    frame_done;

   assign frame_done = busy_q & ~busy;  // engine finished its gap
   assign done = (state == adv_cfg_pkg::FINISHED);

   // mux held in reset until the first edge after rst
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         iic_mux_rst <= 1'b0;
         busy_q <= 1'b0;
      end else begin
         iic_mux_rst <= 1'b1;
         busy_q <= busy;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= adv_cfg_pkg::MUX_RESET;
         start <= 1'b0;
         kind <= iic_pkg::FRAME_MUX;
         index <= '0;
      end else begin
         start <= 1'b0;
         case (state)
            adv_cfg_pkg::MUX_RESET: begin
               if (iic_mux_rst) begin
                  start <= 1'b1;
                  kind <= iic_pkg::FRAME_MUX;
                  state <= adv_cfg_pkg::MUX_WRITE;
               end
            end
            adv_cfg_pkg::MUX_WRITE: begin
               if (frame_done) begin
                  start <= 1'b1;  // table entry 0
                  kind <= iic_pkg::FRAME_REG;
                  state <= adv_cfg_pkg::REG_WRITE;
               end
            end
            adv_cfg_pkg::REG_WRITE: begin
               if (frame_done) begin
                  if (index == last_index) begin
                     state <= adv_cfg_pkg::FINISHED;
                  end else begin
                     index <= index + 1'b1;
                     start <= 1'b1;
                  end
               end
            end
            default: state <= adv_cfg_pkg::FINISHED;  // stay put
         endcase
      end
   end

endmodule

`default_nettype wire

//--- verilog/iic_config_top.sv
// ==============================
// HDMI transmitter configuration master
// drives the mux reset, scl and sda after reset
// and raises done when the table is written
// ==============================

`default_nettype none

`include "iic_config_macros.svh"

module iic_config_top #(
   parameter int phase_cycles = `IIC_PHASE_CYCLES
) (
   input  logic clk,
   input  logic rst,
   output logic scl,
   output logic sda,
   output logic iic_mux_rst,
   output logic done
);

   logic                    start;
   logic                    busy;
   iic_pkg::frame_kind_e    kind;
   adv_cfg_pkg::cfg_index_t index;
   adv_cfg_pkg::cfg_addr_t  reg_addr;
   adv_cfg_pkg::cfg_data_t  reg_data;

   cfg_sequencer u_sequencer (
      .clk         (clk),
      .rst         (rst),
      .busy        (busy),
      .start       (start),
      .kind        (kind),
      .index       (index),
      .iic_mux_rst (iic_mux_rst),
      .done        (done)
   );

   adv_cfg_rom u_rom (
      .index    (index),
      .reg_addr (reg_addr),
      .reg_data (reg_data)
   );

   iic_write_engine #(
      .phase_cycles (phase_cycles)
   ) u_engine (
      .clk      (clk),
      .rst      (rst),
      .start    (start),
      .kind     (kind),
      .reg_addr (reg_addr),
      .reg_data (reg_data),
      .busy     (busy),
      .scl      (scl),
      .sda      (sda)
   );

endmodule

`default_nettype wire

//--- verif/tb_iic_config.sv
// ==============================
// testbench for the HDMI transmitter configuration master
// decodes the I2C frames on scl and sda and compares them
// with the frames listed in the vectors file
// ==============================

`default_nettype none

`include "iic_config_macros.svh"

module tb_iic_config;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int  phase_cycles  = 4;
   localparam real clk_period    = 40.0;
   localparam int  reset_cycles  = 16;
   localparam int  window_cycles = 200 * phase_cycles;  // 200 phases after done
   // 64 frames of at most 32 bits, 4 phases per bit, doubled
   localparam real watchdog_time = 2.0 * 64 * 32 * 4 * phase_cycles * clk_period
                                   + (reset_cycles + window_cycles) * clk_period;

   logic clk;
   logic rst;
   logic scl;
   logic sda;
   logic iic_mux_rst;
   logic done;

   // expected frames
   iic_pkg::frame_kind_e   exp_kind [$];
   iic_pkg::dev_addr_t     exp_dev  [$];
   adv_cfg_pkg::cfg_addr_t exp_addr [$];
   adv_cfg_pkg::cfg_data_t exp_data [$];
   int                     n_vectors = 0;
   int                     test_errors [$];

   // bus monitor state, four byte slots per frame
   logic [7:0] got_byte [$];
   logic       got_ack  [$];
   int         got_bits [$];
   int         mon_faults [$];  // test number of each protocol fault
   int         frames_seen = 0;
   int         starts_seen = 0;
   int         bit_count = 0;
   int         slot = 0;
   logic       in_frame = 1'b0;
   logic       scl_q = 1'b1;
   logic       sda_q = 1'b1;
   logic       done_q = 1'b0;
   logic       mux_rst_high = 1'b0;
   logic [7:0] shift_byte = 8'h00;

   iic_config_top #(
      .phase_cycles (phase_cycles)
   ) DUT (
      .clk         (clk),
      .rst         (rst),
      .scl         (scl),
      .sda         (sda),
      .iic_mux_rst (iic_mux_rst),
      .done        (done)
   );

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2.0) clk = ~clk;
   end

   initial begin
      #(watchdog_time);
      $display("timeout: the configuration did not finish by %0t", $time);
      $display("TEST FAIL");
      $finish;
   end

   task automatic note_fault(input int test, input string what);
      $display("protocol fault at %0t: %s", $time, what);
      mon_faults.push_back(test);
   endtask

   task automatic compare_dev(input int test, input string name,
                              input iic_pkg::dev_addr_t got, input iic_pkg::dev_addr_t exp);
      if (got !== exp) begin
         $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
         test_errors[test] = test_errors[test] + 1;
      end
   endtask

   task automatic compare_addr(input int test, input string name,
                               input adv_cfg_pkg::cfg_addr_t got,
                               input adv_cfg_pkg::cfg_addr_t exp);
      if (got !== exp) begin
         $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
         test_errors[test] = test_errors[test] + 1;
      end
   endtask

   task automatic compare_data(input int test, input string name,
                               input adv_cfg_pkg::cfg_data_t got,
                               input adv_cfg_pkg::cfg_data_t exp);
      if (got !== exp) begin
         $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
         test_errors[test] = test_errors[test] + 1;
      end
   endtask

   task automatic compare_bit(input int test, input string name, input logic got,
                              input logic exp);
      if (got !== exp) begin
         $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
         test_errors[test] = test_errors[test] + 1;
      end
   endtask

   function automatic int count_errors(input int test);
      int n;
      n = test_errors[test];
      foreach (mon_faults[i]) begin
         if (mon_faults[i] == test) n++;
      end
      return n;
   endfunction

   task automatic report_test(input int test, input string title);
      if (count_errors(test) == 0) begin
         $display("test %0d %s: passed", test, title);
      end else begin
         $display("test %0d %s: failed with %0d errors", test, title, count_errors(test));
      end
   endtask

   // one frame against its vector line, frame 0 is the channel select
   task automatic check_frame(input int f);
      int test;
      int exp_bytes;
      int base;
      test = (f == 0) ? 3 : 4;
      exp_bytes = (exp_kind[f] == iic_pkg::FRAME_MUX) ? 2 : 3;
      base = f * 4;
      if (got_bits[f] != exp_bytes * 9) begin
         $display("frame %0d carried %0d bits where %0d were expected",
                  f, got_bits[f], exp_bytes * 9);
         test_errors[test] = test_errors[test] + 1;
      end else begin
         compare_dev(test, "device address", got_byte[base][7:1], exp_dev[f]);
         compare_bit(test, "write bit", got_byte[base][0], 1'b0);
         for (int j = 0; j < exp_bytes; j++) begin
            compare_bit(test, "ack slot", got_ack[base + j], 1'b1);
         end
         if (exp_kind[f] == iic_pkg::FRAME_MUX) begin
            compare_data(test, "channel mask", got_byte[base + 1], exp_data[f]);
         end else begin
            compare_addr(test, "register address", got_byte[base + 1], exp_addr[f]);
            compare_data(test, "register data", got_byte[base + 2], exp_data[f]);
         end
      end
   endtask

   // sampled on the falling clock so both lines are settled
   always @(negedge clk) begin
      if (!rst) begin
         if (mux_rst_high && !iic_mux_rst)
            note_fault(2, "multiplexer reset dropped after it was released");
         mux_rst_high = mux_rst_high | iic_mux_rst;
         if (done && !done_q && frames_seen < n_vectors)
            note_fault(6, "done rose before the final stop condition");
         if (scl_q && scl && sda_q && !sda) begin  // start
            if (!iic_mux_rst)
               note_fault(2, "start condition while the multiplexer is in reset");
            if (in_frame)
               note_fault(5, "start condition before the previous frame was stopped");
            slot = starts_seen;
            starts_seen++;
            repeat (4) begin
               got_byte.push_back(8'h00);
               got_ack.push_back(1'bx);
            end
            got_bits.push_back(-1);
            in_frame = 1'b1;
            bit_count = 0;
         end else if (scl_q && scl && !sda_q && sda) begin  // stop
            if (!in_frame) begin
               note_fault(5, "stop condition without a start");
            end else begin
               got_bits[slot] = bit_count - 1;  // last scl rise belongs to the stop
               frames_seen++;
            end
            in_frame = 1'b0;
         end else if (!scl_q && scl) begin
            if (!in_frame) begin
               note_fault(5, "scl pulse outside a frame");
            end else begin
               if (bit_count % 9 == 8 && bit_count < 36) begin  // ack slot
                  got_byte[slot * 4 + bit_count / 9] = shift_byte;
                  got_ack[slot * 4 + bit_count / 9] = sda;
               end
               shift_byte = {shift_byte[6:0], sda};
               bit_count++;
            end
         end
      end
      scl_q = scl;
      sda_q = sda;
      done_q = done;
   end

   initial begin
      int    fd;
      int    code;
      int    k;
      int    d;
      int    a;
      int    v;
      int    starts_at_done;
      int    total;
      int    failed;
      string line;
      rst = 1'b1;
      repeat (7) test_errors.push_back(0);
      fd = $fopen("verif/iic_config_vectors.txt", "r");
      if (fd == 0) begin
         $display("the vectors file could not be opened");
         test_errors[4] = test_errors[4] + 1;
      end else begin
         while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0 || line.len() == 0 || line.getc(0) == "#") continue;
            if ($sscanf(line, "%d %h %h %h", k, d, a, v) == 4) begin
               exp_kind.push_back((k == 0) ? iic_pkg::FRAME_MUX : iic_pkg::FRAME_REG);
               exp_dev.push_back(iic_pkg::dev_addr_t'(d));
               exp_addr.push_back(adv_cfg_pkg::cfg_addr_t'(a));
               exp_data.push_back(adv_cfg_pkg::cfg_data_t'(v));
            end
         end
         $fclose(fd);
         n_vectors = exp_kind.size();
         if (n_vectors != `ADV_CFG_ENTRIES + 1) begin
            $display("the vectors file lists %0d frames instead of %0d",
                     n_vectors, `ADV_CFG_ENTRIES + 1);
            test_errors[4] = test_errors[4] + 1;
         end

         repeat (reset_cycles) begin
            @(negedge clk);
            compare_bit(1, "scl", scl, 1'b1);
            compare_bit(1, "sda", sda, 1'b1);
            compare_bit(1, "iic_mux_rst", iic_mux_rst, 1'b0);
            compare_bit(1, "done", done, 1'b0);
         end
         rst = 1'b0;
         report_test(1, "reset state");

         while (iic_mux_rst !== 1'b1) @(negedge clk);
         for (int f = 0; f < n_vectors; f++) begin
            while (frames_seen <= f) @(negedge clk);
            check_frame(f);
            if (f == 0) report_test(3, "channel select");
         end

         while (done !== 1'b1) @(negedge clk);
         if (frames_seen != n_vectors) begin
            $display("%0d frames were sent instead of %0d", frames_seen, n_vectors);
            test_errors[4] = test_errors[4] + 1;
         end
         report_test(4, "register table");

         // bus must stay idle with done held
         starts_at_done = starts_seen;
         repeat (window_cycles) begin
            @(negedge clk);
            compare_bit(6, "done", done, 1'b1);
            compare_bit(6, "scl", scl, 1'b1);
            compare_bit(6, "sda", sda, 1'b1);
         end
         if (starts_seen != starts_at_done) begin
            $display("a start condition appeared after done");
            test_errors[6] = test_errors[6] + 1;
         end
         if (in_frame) begin
            $display("a frame was still open at the end of the run");
            test_errors[5] = test_errors[5] + 1;
         end
         report_test(2, "multiplexer reset");
         report_test(5, "line discipline");
         report_test(6, "completion");
      end

      total = 0;
      failed = 0;
      for (int t = 1; t <= 6; t++) begin
         total += count_errors(t);
         if (count_errors(t) != 0) failed++;
      end
      $display("summary: 6 tests, %0d passed, %0d failed, %0d errors",
               6 - failed, failed, total);
      if (total == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- verif/iic_config_vectors.txt
# kind dev reg data, one frame per line, dev reg data in hex
# kind 0 is the mux channel select (reg unused), kind 1 is a register write
0 74 00 20
1 39 41 10
1 39 0B C7
1 39 14 02
1 39 15 00
1 39 16 32
1 39 17 60
1 39 3C 02
1 39 0A 10
1 39 55 00
1 39 73 01
1 39 9D 60
1 39 AF 06
1 39 D7 04
1 39 D8 03
1 39 D9 E0
1 39 DA 24
1 39 DB 06
1 39 F9 00
1 39 3B E0
1 39 44 00
1 39 48 00
1 39 94 C0
1 39 96 00
1 39 98 03
1 39 99 02
1 39 9A E0
1 39 9B 18
1 39 9C 30
1 39 9F 00
1 39 A1 00
1 39 A2 A4
1 39 A3 A4
1 39 A4 08
1 39 A5 04
1 39 A6 00
1 39 A7 00
1 39 A8 00
1 39 A9 00
1 39 AA 00
1 39 AB 40
1 39 B9 00
1 39 BA 10
1 39 BB 00
1 39 C7 00
1 39 CD 00
1 39 CE 01
1 39 CF 04
1 39 D0 3C
1 39 D1 FF
1 39 D2 80
1 39 D3 80
1 39 D4 80
1 39 D5 00
1 39 D6 00
1 39 DC 00
1 39 DD 00
1 39 DE 10
1 39 DF 01
1 39 E0 3C
1 39 E2 00
1 39 E3 00
1 39 E4 60
1 39 FA 00

//--- tb.f
+incdir+verilog
verilog/iic_pkg.sv
verilog/adv_cfg_pkg.sv
verilog/adv_cfg_rom.sv
verilog/iic_write_engine.sv
verilog/cfg_sequencer.sv
verilog/iic_config_top.sv
verif/tb_iic_config.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the configuration master testbench with Verilator
# exit status is 0 only when the log holds no failure

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -f tb.f --top-module tb_iic_config \
   -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
   echo "verilator compile failed"
   exit 1
fi

./obj_dir/sim_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "TEST FAIL" "$log"; then
   exit 1
fi
if ! grep -q "TEST PASS" "$log"; then
   echo "simulation ended without a result line"
   exit 1
fi
exit 0
